//--- Makefile
# Verilator build and run for the writeback subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_wb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG PASS_MSG VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/alu_pipe.sv
/*
 * Single-cycle execute pipe
 * Computes an integer ALU result and holds it in a one-entry output
 * stage until writeback grants it
 */

`timescale 1ns/10ps

module alu_pipe import wb_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  issue_t     issue,
  output logic       issue_rdy,
  output wb_result_t result,
  input  logic       rdy
);

  logic [data_bits-1:0] alu_out;
  logic                 load;

  // Stage frees up when empty or when drained this cycle
  assign issue_rdy = !result.val || rdy;
  assign load      = issue.val && issue_rdy;

  // --------------------
  // ALU
  // --------------------

  always_comb begin
    case (issue.op)
      op_add:  alu_out = issue.src_a + issue.src_b;
      op_sub:  alu_out = issue.src_a - issue.src_b;
      op_and:  alu_out = issue.src_a & issue.src_b;
      op_or:   alu_out = issue.src_a | issue.src_b;
      op_xor:  alu_out = issue.src_a ^ issue.src_b;
      op_slt:  alu_out = {{(data_bits-1){1'b0}},
                          ($signed(issue.src_a) < $signed(issue.src_b))};
      default: alu_out = '0;
    endcase
  end

  // --------------------
  // Output stage
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      result.val <= 1'b0;
    end else if (load) begin
      result <= '{
        val:     1'b1,
        pc:      issue.pc,
        seq_num: issue.seq_num,
        waddr:   issue.waddr,
        wdata:   alu_out,
        wen:     issue.wen
      };
    end else if (rdy) begin
      result.val <= 1'b0;
    end
  end

  // Held result must not move until writeback takes it
  a_hold_stable: assert property (
    @(posedge clk) disable iff (rst)
    (result.val && !rdy) |=> $stable(result)
  );

endmodule

//--- rtl/commit_regfile.sv
/*
 * Architectural register file
 * 32 x 32 bits, written by commit notices, one combinational read port
 */

`timescale 1ns/10ps

module commit_regfile import wb_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  commit_t                  commit,
  input  logic [reg_addr_bits-1:0] rd_addr,
  output logic [data_bits-1:0]     rd_data
);

  logic [data_bits-1:0] regs [num_regs];
  logic                 wr_en;

  assign wr_en = commit.val && commit.wen;

  // --------------------
  // Write port
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[commit.waddr] <= commit.wdata;
    end
  end

  // Read port, observes architectural state
  assign rd_data = regs[rd_addr];

  // Writeback is expected to suppress every register 0 write
  a_no_r0_write: assert property (
    @(posedge clk) disable iff (rst)
    wr_en |-> (commit.waddr != '0)
  );

endmodule

//--- rtl/rr_arb.sv
/*
 * Round-robin arbiter
 * Grants the first requester at or above the priority pointer,
 * then moves the pointer to the pipe after the winner
 */

`timescale 1ns/10ps

module rr_arb import wb_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [num_pipes-1:0] req,
  output logic [num_pipes-1:0] gnt
);

  logic [pipe_idx_bits-1:0] ptr;
  logic [pipe_idx_bits-1:0] ptr_next;

  // Search upward from the pointer with wraparound
  always_comb begin : search
    logic found;
    int   idx;
    gnt      = '0;
    ptr_next = ptr;
    found    = 1'b0;
    for (int k = 0; k < num_pipes; k++) begin
      idx = (int'(ptr) + k) % num_pipes;
      if (!found && req[idx]) begin
        gnt[idx] = 1'b1;
        ptr_next = pipe_idx_bits'((idx + 1) % num_pipes);
        found    = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (|gnt) begin
      ptr <= ptr_next;
    end
  end

  a_gnt_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt));
  a_gnt_in_req: assert property (@(posedge clk) disable iff (rst) (gnt & ~req) == '0);

endmodule

//--- rtl/wb_pkg.sv
/*
 * Writeback subsystem package
 * Widths, pipe count, ALU operation encoding and the structs that
 * carry issues, pipe results and the completion and commit notices
 */

package wb_pkg;

  // --------------------
  // Widths and counts
  // --------------------

  localparam int num_pipes     = 2;
  localparam int pipe_idx_bits = (num_pipes > 1) ? $clog2(num_pipes) : 1;
  localparam int data_bits     = 32;
  localparam int addr_bits     = 32;
  localparam int seq_num_bits  = 8;
  localparam int reg_addr_bits = 5;
  localparam int num_regs      = 2 ** reg_addr_bits;

  // --------------------
  // ALU operations
  // --------------------

  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_and = 3'd2,
    op_or  = 3'd3,
    op_xor = 3'd4,
    op_slt = 3'd5   // signed compare, result is 1 or 0
  } alu_op_e;

  // --------------------
  // Structs
  // --------------------

  // One operation handed to an execute pipe
  typedef struct packed {
    logic                     val;
    logic [addr_bits-1:0]     pc;
    logic [seq_num_bits-1:0]  seq_num;
    alu_op_e                  op;
    logic [data_bits-1:0]     src_a;
    logic [data_bits-1:0]     src_b;
    logic [reg_addr_bits-1:0] waddr;
    logic                     wen;
  } issue_t;

  // Pipe output stage as seen by writeback
  typedef struct packed {
    logic                     val;
    logic [addr_bits-1:0]     pc;
    logic [seq_num_bits-1:0]  seq_num;
    logic [reg_addr_bits-1:0] waddr;
    logic [data_bits-1:0]     wdata;
    logic                     wen;
  } wb_result_t;

  typedef struct packed {
    logic                     val;
    logic [seq_num_bits-1:0]  seq_num;
    logic [reg_addr_bits-1:0] waddr;
    logic [data_bits-1:0]     wdata;
    logic                     wen;
  } complete_t;

  typedef struct packed {
    logic                     val;
    logic [addr_bits-1:0]     pc;
    logic [seq_num_bits-1:0]  seq_num;
    logic [reg_addr_bits-1:0] waddr;
    logic [data_bits-1:0]     wdata;
    logic                     wen;
  } commit_t;

endpackage

//--- rtl/wb_top.sv
/*
 * Writeback subsystem top
 * Two execute pipes feeding the writeback-commit unit and the
 * architectural register file
 */

`timescale 1ns/10ps

module wb_top import wb_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  issue_t                   issue [num_pipes],
  output logic [num_pipes-1:0]     issue_rdy,
  output complete_t                complete,
  output commit_t                  commit,
  input  logic [reg_addr_bits-1:0] rd_addr,
  output logic [data_bits-1:0]     rd_data
);

  wb_result_t           result [num_pipes];
  logic [num_pipes-1:0] rdy;

  // Execute pipes
  for (genvar p = 0; p < num_pipes; p++) begin : g_pipe
    alu_pipe u_pipe (
      .clk       (clk),
      .rst       (rst),
      .issue     (issue[p]),
      .issue_rdy (issue_rdy[p]),
      .result    (result[p]),
      .rdy       (rdy[p])
    );
  end

  writeback_commit_unit u_wb (
    .clk      (clk),
    .rst      (rst),
    .result   (result),
    .rdy      (rdy),
    .complete (complete),
    .commit   (commit)
  );

  commit_regfile u_rf (
    .clk     (clk),
    .rst     (rst),
    .commit  (commit),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

//--- rtl/writeback_commit_unit.sv
/*
 * Writeback and commit unit
 * Picks one waiting pipe per cycle round-robin, reports completion in
 * the grant cycle and commit one cycle later
 */

`timescale 1ns/10ps

module writeback_commit_unit import wb_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  wb_result_t           result [num_pipes],
  output logic [num_pipes-1:0] rdy,
  output complete_t            complete,
  output commit_t              commit
);

  logic [num_pipes-1:0] req;
  logic [num_pipes-1:0] gnt;
  wb_result_t           masked [num_pipes];
  wb_result_t           sel;
  logic                 sel_wen;

  // --------------------
  // Arbitration
  // --------------------

  for (genvar p = 0; p < num_pipes; p++) begin : g_req
    assign req[p]    = result[p].val;
    assign masked[p] = wb_result_t'(result[p] & {$bits(wb_result_t){gnt[p]}});
  end

  rr_arb u_arb (
    .clk (clk),
    .rst (rst),
    .req (req),
    .gnt (gnt)
  );

  // Grant doubles as ready, no other back-pressure
  assign rdy = gnt;

  // At most one grant, so OR of masked results is a mux
  always_comb begin
    sel = '0;
    for (int p = 0; p < num_pipes; p++) begin
      sel = wb_result_t'(sel | masked[p]);
    end
  end

  // Register 0 is never written
  assign sel_wen = sel.wen && (sel.waddr != '0);

  // --------------------
  // Notices
  // --------------------

  assign complete = '{
    val:     sel.val,
    seq_num: sel.seq_num,
    waddr:   sel.waddr,
    wdata:   sel.wdata,
    wen:     sel_wen
  };

  always_ff @(posedge clk) begin
    if (rst) begin
      commit.val <= 1'b0;
      commit.wen <= 1'b0;
    end else begin
      commit <= '{
        val:     sel.val,
        pc:      sel.pc,
        seq_num: sel.seq_num,
        waddr:   sel.waddr,
        wdata:   sel.wdata,
        wen:     sel_wen
      };
    end
  end

  // Commit trails completion by exactly one cycle
  a_commit_follows: assert property (
    @(posedge clk) disable iff (rst)
    !$past(rst) |-> (commit.val == $past(complete.val))
  );

endmodule

//--- sim/tb_wb_top.sv
/*
 * Directed testbench for the writeback subsystem
 * A commit monitor checks every notice against an ALU and register file model
 */

`timescale 1ns/10ps

module tb_wb_top import wb_pkg::*; ();

  localparam int clk_half   = 10;
  localparam int num_seq    = 2 ** seq_num_bits;
  // Rough cycle budget per test: reset, single, ops, r0, no-write, contention, stream, final
  localparam int max_cycles = 2 * (6 + 10 + 60 + 10 + 20 + 26 + 200 + 2 * num_regs);

  logic                     clk;
  logic                     rst;
  issue_t                   issue [num_pipes];
  logic [num_pipes-1:0]     issue_rdy;
  complete_t                complete;
  commit_t                  commit;
  logic [reg_addr_bits-1:0] rd_addr;
  logic [data_bits-1:0]     rd_data;

  // Model state, indexed by sequence number
  logic [addr_bits-1:0]     exp_pc    [num_seq];
  logic [reg_addr_bits-1:0] exp_waddr [num_seq];
  logic [data_bits-1:0]     exp_wdata [num_seq];
  logic                     exp_wen   [num_seq];
  logic                     issued    [num_seq];
  logic                     done      [num_seq];
  int                       commit_at [num_seq];
  logic [data_bits-1:0]     ref_regs  [num_regs];
  int                       commit_log [$];

  int   seed        = 43343;
  int   errors      = 0;
  int   n_checks    = 0;
  int   cycles      = 0;
  int   next_seq    = 0;
  int   n_issued    = 0;
  int   n_committed = 0;
  logic                    prev_cpl_val;
  logic [seq_num_bits-1:0] prev_cpl_seq;

  wb_top u_dut (
    .clk       (clk),
    .rst       (rst),
    .issue     (issue),
    .issue_rdy (issue_rdy),
    .complete  (complete),
    .commit    (commit),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #clk_half clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", max_cycles);
      $display("Checks failed");
      $finish;
    end
  end

  // --------------------
  // Model
  // --------------------

  function automatic logic [data_bits-1:0] alu_ref(input alu_op_e op,
                                                   input logic [data_bits-1:0] a,
                                                   input logic [data_bits-1:0] b);
    case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_and:  return a & b;
      op_or:   return a | b;
      op_xor:  return a ^ b;
      // Signs differ, so the negative operand is the smaller one
      op_slt:  return (a[data_bits-1] != b[data_bits-1]) ? data_bits'(a[data_bits-1]) :
                                                            data_bits'(a < b);
      default: return '0;
    endcase
  endfunction

  function automatic complete_t exp_complete(input int s);
    return '{val: 1'b1, seq_num: seq_num_bits'(s), waddr: exp_waddr[s],
             wdata: exp_wdata[s], wen: exp_wen[s]};
  endfunction

  function automatic commit_t exp_commit(input int s);
    return '{val: 1'b1, pc: exp_pc[s], seq_num: seq_num_bits'(s), waddr: exp_waddr[s],
             wdata: exp_wdata[s], wen: exp_wen[s]};
  endfunction

  // --------------------
  // Compare tasks
  // --------------------

  task automatic check_commit(input commit_t got, input commit_t exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] commit: got %h, expected %h", got, exp);
    end
  endtask

  task automatic check_complete(input complete_t got, input complete_t exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] complete: got %h, expected %h", got, exp);
    end
  endtask

  task automatic check_data(input string name, input logic [data_bits-1:0] got,
                            input logic [data_bits-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // Commit must trail the completion of the same seq by one cycle
  always @(negedge clk) begin : monitor
    int s;
    if (rst) begin
      prev_cpl_val = 1'b0;
    end else begin
      if (complete.val && !issued[complete.seq_num]) begin
        errors++;
        $display("Completion seen for seq %0d, which was never issued", complete.seq_num);
      end else if (complete.val) begin
        check_complete(complete, exp_complete(int'(complete.seq_num)));
      end
      if (commit.val !== prev_cpl_val || (commit.val && commit.seq_num != prev_cpl_seq)) begin
        errors++;
        $display("Commit does not match the completion one cycle earlier");
      end
      if (commit.val && issued[commit.seq_num]) begin
        s = int'(commit.seq_num);
        check_commit(commit, exp_commit(s));
        if (done[s]) begin
          errors++;
          $display("Seq %0d committed more than once", s);
        end else begin
          n_committed++;
        end
        done[s]      = 1'b1;
        commit_at[s] = cycles;
        commit_log.push_back(s);
        if (exp_wen[s]) begin
          ref_regs[exp_waddr[s]] = exp_wdata[s];
        end
      end
      prev_cpl_val = complete.val;
      prev_cpl_seq = complete.seq_num;
    end
  end

  // --------------------
  // Drive helpers
  // --------------------

  task automatic do_reset();
    @(negedge clk);
    rst = 1'b1;
    foreach (issue[p]) begin
      issue[p] = '0;
    end
    foreach (ref_regs[i]) begin
      ref_regs[i] = '0;
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic set_issue(input int p, input alu_op_e op, input logic [data_bits-1:0] a,
                           input logic [data_bits-1:0] b,
                           input logic [reg_addr_bits-1:0] waddr, input logic wen,
                           output int seq);
    seq = next_seq;
    next_seq++;
    n_issued++;
    issued[seq]    = 1'b1;
    exp_pc[seq]    = 32'h0000_1000 + 32'(seq * 4);
    exp_waddr[seq] = waddr;
    exp_wdata[seq] = alu_ref(op, a, b);
    exp_wen[seq]   = wen && (waddr != '0);
    issue[p] = '{val: 1'b1, pc: exp_pc[seq], seq_num: seq_num_bits'(seq), op: op,
                 src_a: a, src_b: b, waddr: waddr, wen: wen};
  endtask

  function automatic logic pending();
    logic any;
    any = 1'b0;
    foreach (issue[p]) begin
      any = any | issue[p].val;
    end
    return any;
  endfunction

  // Issues seen ready now are taken at the coming edge
  task automatic advance();
    logic [num_pipes-1:0] taken;
    for (int p = 0; p < num_pipes; p++) begin
      taken[p] = issue[p].val && issue_rdy[p];
    end
    @(negedge clk);
    for (int p = 0; p < num_pipes; p++) begin
      if (taken[p]) begin
        issue[p].val = 1'b0;
      end
    end
  endtask

  task automatic run_issues();
    while (pending()) begin
      advance();
    end
  endtask

  task automatic wait_idle();
    while (n_committed < n_issued) begin
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  task automatic check_reg(input int idx, input logic [data_bits-1:0] exp);
    rd_addr = reg_addr_bits'(idx);
    #(clk_half / 2);
    check_data($sformatf("rd_data[%0d]", idx), rd_data, exp);
    @(negedge clk);
  endtask

  task automatic check_order(input int pos, input int first, input int second);
    n_checks++;
    if (commit_log.size() < pos + 2 || commit_log[pos] != first ||
        commit_log[pos + 1] != second || commit_at[second] != commit_at[first] + 1) begin
      errors++;
      $display("Seq %0d then %0d did not commit in that order on consecutive cycles",
               first, second);
    end
  endtask

  // --------------------
  // Tests
  // --------------------

  task automatic test_single();
    int s;
    set_issue(0, op_add, 32'h1234_5678, 32'h0000_1111, 5'd3, 1'b1, s);
    run_issues();
    check_complete(complete, exp_complete(s));
    @(negedge clk);
    check_commit(commit, exp_commit(s));
    @(negedge clk);
    check_reg(3, 32'h1234_6789);
  endtask

  task automatic test_all_ops();
    int s;
    logic [data_bits-1:0] a;
    logic [data_bits-1:0] b;
    for (int k = 0; k < 6; k++) begin
      a = $random(seed);
      b = $random(seed);
      set_issue(1, alu_op_e'(k), a, b, reg_addr_bits'(k + 1), 1'b1, s);
      run_issues();
      wait_idle();
      check_reg(k + 1, alu_ref(alu_op_e'(k), a, b));
    end
  endtask

  task automatic test_reg0();
    int s;
    set_issue(0, op_or, 32'hdead_beef, 32'h0, 5'd0, 1'b1, s);
    run_issues();
    check_complete(complete, exp_complete(s));
    wait_idle();
    check_reg(0, '0);
  endtask

  task automatic test_no_write();
    int s;
    set_issue(0, op_add, 32'h0000_00a5, 32'h0, 5'd9, 1'b1, s);
    run_issues();
    wait_idle();
    set_issue(1, op_xor, $random(seed), $random(seed), 5'd9, 1'b0, s);
    run_issues();
    wait_idle();
    check_reg(9, 32'h0000_00a5);
  endtask

  task automatic test_contention();
    int s0;
    int s1;
    int base;
    do_reset();
    base = commit_log.size();
    set_issue(0, op_add, $random(seed), $random(seed), 5'd10, 1'b1, s0);
    set_issue(1, op_sub, $random(seed), $random(seed), 5'd11, 1'b1, s1);
    run_issues();
    // Pipe 0 drains this cycle, pipe 1 still waits for its grant
    n_checks++;
    if (issue_rdy !== 2'b01) begin
      errors++;
      $display("[FAIL] issue_rdy: got %h, expected %h", issue_rdy, 2'b01);
    end
    wait_idle();
    check_order(base, s0, s1);
    // Pointer sits at pipe 0 again after pipe 1's grant
    set_issue(0, op_and, $random(seed), $random(seed), 5'd12, 1'b1, s0);
    set_issue(1, op_slt, $random(seed), $random(seed), 5'd13, 1'b1, s1);
    run_issues();
    wait_idle();
    check_order(base + 2, s0, s1);
  endtask

  task automatic test_stream();
    int          left;
    int          s;
    int unsigned r;
    left = 40;
    while (left > 0 || pending()) begin
      for (int p = 0; p < num_pipes; p++) begin
        r = $random(seed);
        if (!issue[p].val && left > 0 && r[0]) begin
          set_issue(p, alu_op_e'((r >> 8) % 6), $random(seed), $random(seed),
                    r[20:16], r[1] | r[2], s);
          left--;
        end
      end
      advance();
    end
    wait_idle();
  endtask

  task automatic final_check();
    for (int i = 0; i < num_regs; i++) begin
      check_reg(i, ref_regs[i]);
    end
    for (int s = 0; s < next_seq; s++) begin
      if (!done[s]) begin
        errors++;
        $display("Seq %0d was issued but never committed", s);
      end
    end
  endtask

  initial begin
    rst     = 1'b1;
    rd_addr = '0;
    foreach (issue[p]) begin
      issue[p] = '0;
    end
    foreach (issued[s]) begin
      issued[s] = 1'b0;
      done[s]   = 1'b0;
    end
    prev_cpl_val = 1'b0;
    prev_cpl_seq = '0;
    do_reset();
    test_single();
    test_all_ops();
    test_reg0();
    test_no_write();
    test_contention();
    test_stream();
    final_check();
    $display("Checks run: %0d, errors: %0d", n_checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- tb.f
rtl/wb_pkg.sv
rtl/rr_arb.sv
rtl/alu_pipe.sv
rtl/writeback_commit_unit.sv
rtl/commit_regfile.sv
rtl/wb_top.sv
sim/tb_wb_top.sv
